// ==== files.f ====
+incdir+testbench
rtl/posit_cfg_pkg.sv
rtl/posit_types_pkg.sv
rtl/posit_decode.sv
rtl/posit_mult_core.sv
rtl/posit_round_encode.sv
rtl/posit_mult_top.sv
testbench/posit_mult_tb.sv

// ==== rtl/posit_cfg_pkg.sv ====
////////////////////////////////////////
// Posit format configuration
// Widths and constants for the multiplier
////////////////////////////////////////
`default_nettype none

package posit_cfg_pkg;

    // Posit format, 16 bits with one exponent bit
    localparam int POSIT_N  = 16;
    localparam int POSIT_ES = 1;

    // Signed regime, scale and fraction widths
    localparam int REGIME_W = $clog2(POSIT_N) + 2;
    localparam int SCALE_W  = REGIME_W + POSIT_ES + 1;
    localparam int FRAC_W   = POSIT_N - POSIT_ES - 2;
    localparam int PROD_W   = 2 * FRAC_W;

    // Fraction bits kept below the hidden one after the multiply
    localparam int RAW_FRAC_W = POSIT_N;

    // Encode word: run bit, terminator, exponent, fraction, pad
    localparam int WORD_W = 2 + POSIT_ES + RAW_FRAC_W + POSIT_N;

    // Regime limits before the result saturates
    localparam int REGIME_MAX = POSIT_N - 2;
    localparam int REGIME_MIN = -(POSIT_N - 1);

    // Special bit patterns
    localparam logic [POSIT_N-1:0] POSIT_NAR    = {1'b1, {(POSIT_N-1){1'b0}}};
    localparam logic [POSIT_N-1:0] POSIT_MAXPOS = {1'b0, {(POSIT_N-1){1'b1}}};
    localparam logic [POSIT_N-1:0] POSIT_MINPOS = {{(POSIT_N-1){1'b0}}, 1'b1};

endpackage

`default_nettype wire

// ==== rtl/posit_decode.sv ====
////////////////////////////////////////
// Input stage of the posit multiplier
// Splits both operands, one register
////////////////////////////////////////
`default_nettype none

module posit_decode
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  logic [posit_cfg_pkg::POSIT_N-1:0] a_i,
    input  logic [posit_cfg_pkg::POSIT_N-1:0] b_i,
    output posit_types_pkg::dec_pair_t        dec_o,
    output logic                              dec_valid_o
);

    import posit_cfg_pkg::*;
    import posit_types_pkg::*;

    dec_pair_t dec_d;

    ////////////////////////////////////////
    // Operand decoder
    ////////////////////////////////////////

    function automatic posit_dec_t decode_posit(input logic [POSIT_N-1:0] p);
        posit_dec_t                 d;
        logic [POSIT_N-1:0]         mag;
        logic                       run_bit;
        logic                       run_done;
        logic [REGIME_W-1:0]        run_len;
        logic signed [REGIME_W-1:0] regime;
        logic [POSIT_N-2:0]         rest;
        logic [POSIT_ES-1:0]        expo;

        // Special patterns
        d.sign    = p[POSIT_N-1];
        d.is_zero = (p == '0);
        d.is_nar  = (p == POSIT_NAR);

        // Negative posits are decoded from their two's complement
        mag = p[POSIT_N-1] ? -p : p;

        // Leading run, first regime bit included
        run_bit  = mag[POSIT_N-2];
        run_len  = REGIME_W'(1);
        run_done = 1'b0;
        for (int i = POSIT_N - 3; i >= 0; i--)
        begin
            // Stop at the first bit that breaks the run
            if (!run_done && mag[i] == run_bit)
                run_len = run_len + 1'b1;
            else
                run_done = 1'b1;
        end

        // Run of ones counts up from zero, run of zeros counts down
        regime = run_bit ? $signed(run_len - 1'b1) : -$signed(run_len);

        // Drop run and terminator, exponent ends up on top
        rest = mag[POSIT_N-2:0] << (run_len + 1'b1);
        expo = rest[POSIT_N-2 -: POSIT_ES];

        // Missing low bits come out as zeros
        d.frac  = {1'b1, rest[POSIT_N-2-POSIT_ES -: FRAC_W-1]};
        d.scale = $signed({regime, expo});

        return d;
    endfunction

    ////////////////////////////////////////
    // Both operands in parallel
    ////////////////////////////////////////

    always_comb
    begin
        dec_d.a = decode_posit(a_i);
        dec_d.b = decode_posit(b_i);
    end

    // Valid strobe, one cycle behind the inputs
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            dec_valid_o <= 1'b0;
        else
            dec_valid_o <= valid_i;
    end

    // Payload only loads on a valid item
    always_ff @(posedge clk_i)
    begin
        if (valid_i)
            dec_o <= dec_d;
    end

endmodule

`default_nettype wire

// ==== rtl/posit_mult_core.sv ====
////////////////////////////////////////
// Multiply stage of the posit multiplier
// Fraction product, normalize, scale sum
////////////////////////////////////////
`default_nettype none

module posit_mult_core
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  posit_types_pkg::dec_pair_t dec_i,
    input  logic                       dec_valid_i,
    output posit_types_pkg::mult_raw_t raw_o,
    output logic                       raw_valid_o
);

    import posit_cfg_pkg::*;
    import posit_types_pkg::*;

    logic [PROD_W-1:0]         prod;
    logic [PROD_W-1:0]         prod_n;
    logic                      ovf;
    logic signed [SCALE_W-1:0] scale_inc;
    mult_raw_t                 raw_d;

    ////////////////////////////////////////
    // Product and normalization
    ////////////////////////////////////////

    always_comb
    begin
        // Both fractions in [1,2), product in [1,4)
        prod = dec_i.a.frac * dec_i.b.frac;

        // Product at 2 or above moves down one place
        ovf       = prod[PROD_W-1];
        prod_n    = ovf ? (prod >> 1) : prod;
        scale_inc = {{(SCALE_W-1){1'b0}}, ovf};

        // Hidden one now at PROD_W-2
        raw_d.frac   = prod_n[PROD_W-3 -: RAW_FRAC_W];
        // Bit shifted out on overflow is part of the sticky too
        raw_d.sticky = (|prod_n[PROD_W-3-RAW_FRAC_W:0]) | (ovf & prod[0]);

        raw_d.scale = dec_i.a.scale + dec_i.b.scale + scale_inc;
        raw_d.sign  = dec_i.a.sign ^ dec_i.b.sign;

        // NaR wins over zero
        raw_d.is_nar  = dec_i.a.is_nar | dec_i.b.is_nar;
        raw_d.is_zero = ~raw_d.is_nar & (dec_i.a.is_zero | dec_i.b.is_zero);
    end

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            raw_valid_o <= 1'b0;
        else
            raw_valid_o <= dec_valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (dec_valid_i)
            raw_o <= raw_d;
    end

endmodule

`default_nettype wire

// ==== rtl/posit_mult_top.sv ====
////////////////////////////////////////
// Posit multiplier top level
// Decode, multiply, round in three stages
////////////////////////////////////////
`default_nettype none

module posit_mult_top
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  logic [posit_cfg_pkg::POSIT_N-1:0] a_i,
    input  logic [posit_cfg_pkg::POSIT_N-1:0] b_i,
    output logic [posit_cfg_pkg::POSIT_N-1:0] result_o,
    output logic                              valid_o
);

    import posit_types_pkg::*;

    // Decode to multiply
    dec_pair_t dec;
    logic      dec_valid;

    // Multiply to round
    mult_raw_t raw;
    logic      raw_valid;

    ////////////////////////////////////////
    // Stage 1, operand decode
    ////////////////////////////////////////

    posit_decode u_decode
    (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .dec_o       (dec),
        .dec_valid_o (dec_valid)
    );

    ////////////////////////////////////////
    // Stage 2, fraction multiply
    ////////////////////////////////////////

    posit_mult_core u_core
    (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dec_i       (dec),
        .dec_valid_i (dec_valid),
        .raw_o       (raw),
        .raw_valid_o (raw_valid)
    );

    ////////////////////////////////////////
    // Stage 3, round and encode
    ////////////////////////////////////////

    // Result and valid leave together, three cycles after the input
    posit_round_encode u_round
    (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .raw_i       (raw),
        .raw_valid_i (raw_valid),
        .result_o    (result_o),
        .valid_o     (valid_o)
    );

endmodule

`default_nettype wire

// ==== rtl/posit_round_encode.sv ====
////////////////////////////////////////
// Output stage of the posit multiplier
// Encode, round to nearest even, saturate
////////////////////////////////////////
`default_nettype none

module posit_round_encode
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  posit_types_pkg::mult_raw_t        raw_i,
    input  logic                              raw_valid_i,
    output logic [posit_cfg_pkg::POSIT_N-1:0] result_o,
    output logic                              valid_o
);

    import posit_cfg_pkg::*;
    import posit_types_pkg::*;

    logic signed [SCALE_W-1:0] regime;
    logic [POSIT_ES-1:0]       expo;
    logic                      rneg;
    logic [SCALE_W-1:0]        shamt;
    logic signed [WORD_W-1:0]  word;
    logic signed [WORD_W-1:0]  word_sh;
    logic [POSIT_N-2:0]        body;
    logic [POSIT_N-2:0]        body_rnd;
    logic                      lsb;
    logic                      guard;
    logic                      sticky;
    logic                      ulp;
    logic [POSIT_N-1:0]        mag;
    logic [POSIT_N-1:0]        result_d;

    ////////////////////////////////////////
    // Regime, exponent and fraction layout
    ////////////////////////////////////////

    always_comb
    begin
        // Split scale, exponent is the low ES bits
        regime = $signed(raw_i.scale) >>> POSIT_ES;
        expo   = raw_i.scale[POSIT_ES-1:0];
        rneg   = regime[SCALE_W-1];

        // Run length minus one, r for r >= 0 and -r-1 below
        shamt = rneg ? ~regime : regime;

        // Leading run bit, terminator, exponent, fraction, zero pad
        word    = {~rneg, rneg, expo, raw_i.frac, {POSIT_N{1'b0}}};
        // Arithmetic shift grows the run
        word_sh = word >>> shamt;

        // Bits below the sign
        body = word_sh[WORD_W-1 -: POSIT_N-1];

        // Round to nearest, ties to even
        lsb    = body[0];
        guard  = word_sh[WORD_W-POSIT_N];
        sticky = (|word_sh[WORD_W-POSIT_N-1:0]) | raw_i.sticky;
        ulp    = guard & (lsb | sticky);

        // Unclamped regime always leaves a zero in body, so no carry out
        body_rnd = body + ulp;

        // Never round to zero or past maxpos
        if (regime >= REGIME_MAX)
            mag = POSIT_MAXPOS;
        else if (regime <= REGIME_MIN)
            mag = POSIT_MINPOS;
        else
            mag = {1'b0, body_rnd};

        // Negative result is the two's complement
        if (raw_i.is_nar)
            result_d = POSIT_NAR;
        else if (raw_i.is_zero)
            result_d = '0;
        else
            result_d = raw_i.sign ? -mag : mag;
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= raw_valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (raw_valid_i)
            result_o <= result_d;
    end

endmodule

`default_nettype wire

// ==== rtl/posit_types_pkg.sv ====
////////////////////////////////////////
// Stage payload types
// Decoded operands and raw products
////////////////////////////////////////
`default_nettype none

package posit_types_pkg;

    import posit_cfg_pkg::*;

    ////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////

    // One operand split into its parts
    // Scale is regime * 2^ES + exponent
    typedef struct packed {
        logic                       sign;
        logic                       is_zero;
        logic                       is_nar;
        logic signed [SCALE_W-1:0]  scale;
        // Hidden one on top
        logic [FRAC_W-1:0]          frac;
    } posit_dec_t;

    // Both operands of one multiply
    typedef struct packed {
        posit_dec_t a;
        posit_dec_t b;
    } dec_pair_t;

    ////////////////////////////////////////
    // Multiply stage
    ////////////////////////////////////////

    // Normalized product, ready for rounding
    // Hidden one dropped, lower bits folded into sticky
    typedef struct packed {
        logic                       sign;
        logic                       is_zero;
        logic                       is_nar;
        logic signed [SCALE_W-1:0]  scale;
        logic [RAW_FRAC_W-1:0]      frac;
        logic                       sticky;
    } mult_raw_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the posit multiplier testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module posit_mult_tb \
    && ./obj_dir/Vposit_mult_tb | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/posit_ref_model.svh ====
////////////////////////////////////////
// Behavioral posit decode, multiply and round
////////////////////////////////////////
`ifndef POSIT_REF_MODEL_SVH
`define POSIT_REF_MODEL_SVH

// Hidden one of a decoded mantissa sits at this bit
localparam int MANT_FB = 16;

// Exact value is 2^scale * mant / 2^MANT_FB
function automatic void decode_exact(input logic [POSIT_N-1:0] p, output int scale,
                                     output longint unsigned mant);
    logic [POSIT_N-1:0] x;
    logic               run;
    int                 i;
    int                 k;
    x   = p[POSIT_N-1] ? (~p + 1'b1) : p;
    run = x[POSIT_N-2];
    k   = 0;
    // Length of the regime run
    for (i = POSIT_N - 2; i >= 0; i--)
    begin
        if (x[i] != run)
            break;
        k++;
    end
    scale = (run ? k - 1 : -k) * (1 << POSIT_ES);
    // Skip the terminator
    i--;
    // Exponent bits, zero once the word runs out
    for (int j = POSIT_ES - 1; j >= 0; j--)
    begin
        if (i >= 0 && x[i])
            scale = scale + (1 << j);
        i--;
    end
    mant = 64'd1 << MANT_FB;
    for (int j = MANT_FB - 1; j >= 0 && i >= 0; j--)
    begin
        mant[j] = x[i];
        i--;
    end
endfunction

// Bit string rounding, nearest with ties to even, clamps at maxpos and minpos
function automatic logic [POSIT_N-1:0] round_to_posit(input logic sign, input int scale,
                                                      input longint unsigned mant,
                                                      input int fb);
    logic [127:0]       str;
    logic [POSIT_N-2:0] body;
    logic [POSIT_N-1:0] mag;
    int                 pos;
    int                 r;
    int                 e;
    r = scale >>> POSIT_ES;
    e = scale - r * (1 << POSIT_ES);
    if (r >= POSIT_N - 2)
        mag = POSIT_MAXPOS;
    else if (r <= -(POSIT_N - 1))
        mag = POSIT_MINPOS;
    else
    begin
        // Sign bit left as zero, then regime, exponent and fraction
        str = '0;
        pos = 126;
        if (r >= 0)
            pos = pos - (r + 2);
        else
            pos = pos + r;
        if (r >= 0)
            str[126 -: POSIT_N] = {POSIT_N{1'b1}} << (POSIT_N - r - 1);
        else
            str[pos] = 1'b1;
        if (r < 0)
            pos--;
        for (int j = POSIT_ES - 1; j >= 0; j--)
        begin
            str[pos] = e[j];
            pos--;
        end
        for (int j = fb - 1; j >= 0; j--)
        begin
            str[pos] = mant[j];
            pos--;
        end
        body = str[126 -: POSIT_N-1];
        // Guard is the first dropped bit, sticky is the rest
        if (str[127-POSIT_N] && (body[0] || (|(str << (POSIT_N + 1)))))
            body = body + 1'b1;
        mag = {1'b0, body};
    end
    return sign ? (~mag + 1'b1) : mag;
endfunction

// Exact product of two posits, rounded once
function automatic logic [POSIT_N-1:0] multiply_exact(input logic [POSIT_N-1:0] a,
                                                      input logic [POSIT_N-1:0] b);
    int              sa;
    int              sb;
    int              fb;
    longint unsigned ma;
    longint unsigned mb;
    longint unsigned prod;
    if (a == POSIT_NAR || b == POSIT_NAR)
        return POSIT_NAR;
    if (a == '0 || b == '0)
        return '0;
    decode_exact(a, sa, ma);
    decode_exact(b, sb, mb);
    prod = ma * mb;
    fb   = 2 * MANT_FB;
    // Product in [2,4) carries one more scale step
    if ((prod >> (fb + 1)) != 0)
    begin
        sa++;
        fb++;
    end
    return round_to_posit(a[POSIT_N-1] ^ b[POSIT_N-1], sa + sb, prod, fb);
endfunction

`endif

// ==== testbench/posit_mult_tb.sv ====
////////////////////////////////////////
// Testbench for the posit multiplier
// Clock, stimulus, checks against a model
////////////////////////////////////////
`default_nettype none

module posit_mult_tb;

    import posit_cfg_pkg::*;

    `include "posit_ref_model.svh"

    localparam int HALF_PERIOD   = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int LATENCY       = 3;
    localparam int DRAIN_TIMEOUT = 20;
    localparam logic [POSIT_N-1:0] POSIT_ONE = {2'b01, {(POSIT_N-2){1'b0}}};

    // Directed pairs with operand a in the upper half
    localparam logic [31:0] DIRECTED [14] = '{
        32'h4001_5800, 32'h4003_5800, 32'h4001_4001, 32'h47ff_4801,
        32'h7ff0_4001, 32'h6001_5800,
        // Beyond maxpos
        32'h7fff_7fff, 32'h7fc0_7fc0, 32'h7fff_5000,
        // Below minpos
        32'h0001_0001, 32'h0040_0040, 32'h0001_3000,
        // Negative clamps
        32'h8001_7fff, 32'hffff_0001
    };

    // Expected result with its operands and issue cycle
    typedef struct packed {
        logic [POSIT_N-1:0] result;
        logic [POSIT_N-1:0] a;
        logic [POSIT_N-1:0] b;
        logic [31:0]        stamp;
        logic               neg_check;
    } expect_t;

    logic               clk;
    logic               rst_n;
    logic               valid_in;
    logic [POSIT_N-1:0] a;
    logic [POSIT_N-1:0] b;
    logic [POSIT_N-1:0] result;
    logic               valid_out;

    expect_t            expq[$];
    expect_t            item;
    logic [POSIT_N-1:0] prev_result;
    logic [POSIT_N-1:0] ra;
    logic [POSIT_N-1:0] rb;
    logic [31:0]        cyc = '0;
    integer             seed;
    int                 value_errors;
    int                 timing_errors;
    int                 protocol_errors;
    int                 checked;

    posit_mult_top uut
    (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .valid_i  (valid_in),
        .a_i      (a),
        .b_i      (b),
        .result_o (result),
        .valid_o  (valid_out)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Cycle stamp for the latency check
    always @(posedge clk)
        cyc <= cyc + 1;

    ////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////

    task automatic drive_pair(input logic [POSIT_N-1:0] op_a, input logic [POSIT_N-1:0] op_b,
                              input logic [POSIT_N-1:0] expected, input logic neg_check);
        expect_t e;
        @(posedge clk);
        #DRIVE_DELAY;
        valid_in    = 1'b1;
        a           = op_a;
        b           = op_b;
        e.result    = expected;
        e.a         = op_a;
        e.b         = op_b;
        e.stamp     = cyc;
        e.neg_check = neg_check;
        expq.push_back(e);
    endtask

    task automatic drive_checked(input logic [POSIT_N-1:0] op_a, input logic [POSIT_N-1:0] op_b);
        drive_pair(op_a, op_b, multiply_exact(op_a, op_b), 1'b0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            valid_in = 1'b0;
        end
    endtask

    // Bounded wait for the pipeline to empty
    task automatic wait_drain();
        int n;
        n = 0;
        while (expq.size() > 0 && n < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (expq.size() > 0)
        begin
            $display("Timeout: %0d results never came out of the pipeline", expq.size());
            protocol_errors += expq.size();
        end
    endtask

    ////////////////////////////////////////
    // Checker sampling mid cycle
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!rst_n && cyc > 0)
            assert (valid_out === 1'b0)
            else
            begin
                $display("valid_o is not low while reset is held");
                protocol_errors++;
            end
        if (rst_n)
        begin
            assert (!$isunknown(valid_out))
            else
            begin
                $display("valid_o is unknown after reset at cycle %0d", cyc);
                protocol_errors++;
            end
            if (valid_out === 1'b1)
            begin
                assert (expq.size() > 0)
                else
                begin
                    $display("valid_o went high with no result pending at cycle %0d", cyc);
                    protocol_errors++;
                end
                if (expq.size() > 0)
                begin
                    item = expq.pop_front();
                    checked++;
                    assert (result === item.result)
                    else
                    begin
                        $display("CHECK FAILED result_o: got %h expected %h (a=%h b=%h)",
                                 result, item.result, item.a, item.b);
                        value_errors++;
                    end
                    assert (cyc == item.stamp + LATENCY)
                    else
                    begin
                        $display("Result for a=%h b=%h came at cycle %0d, expected cycle %0d",
                                 item.a, item.b, cyc, item.stamp + LATENCY);
                        timing_errors++;
                    end
                    // Negated operand gives the negated earlier result
                    if (item.neg_check)
                        assert (result === POSIT_N'(~prev_result + 1'b1))
                        else
                        begin
                            $display("CHECK FAILED result_o: got %h expected %h (negation)",
                                     result, POSIT_N'(~prev_result + 1'b1));
                            value_errors++;
                        end
                    prev_result = result;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial
    begin
        seed     = 32'hdec1_79d3;
        rst_n    = 1'b0;
        valid_in = 1'b0;
        a        = '0;
        b        = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // Quiet output before the first item
        idle_cycles(5);

        // Zero, NaR and one
        repeat (8)
        begin
            ra = POSIT_N'($random(seed));
            drive_checked('0, ra);
            drive_checked(ra, '0);
            drive_checked(POSIT_NAR, ra);
            drive_pair(POSIT_ONE, ra, ra, 1'b0);
        end
        drive_checked(POSIT_NAR, '0);
        drive_checked('0, POSIT_NAR);
        idle_cycles(4);

        // Back to back random pairs
        repeat (200)
            drive_checked(POSIT_N'($random(seed)), POSIT_N'($random(seed)));
        idle_cycles(3);

        // Sign rule
        repeat (20)
        begin
            ra = POSIT_N'($random(seed));
            rb = POSIT_N'($random(seed));
            drive_checked(ra, rb);
            ra = ~ra + 1'b1;
            drive_pair(ra, rb, multiply_exact(ra, rb), 1'b1);
        end
        idle_cycles(2);

        // Ties, near ties and clamps
        foreach (DIRECTED[i])
            drive_checked(DIRECTED[i][31:16], DIRECTED[i][15:0]);

        // Sparse items with idle gaps
        repeat (150)
        begin
            if (($random(seed) & 3) == 0)
                drive_checked(POSIT_N'($random(seed)), POSIT_N'($random(seed)));
            else
                idle_cycles(1);
        end

        idle_cycles(1);
        wait_drain();
        // Room for a stray valid_o
        idle_cycles(5);
        $display("Checked %0d results: %0d value errors, %0d timing errors, %0d protocol errors",
                 checked, value_errors, timing_errors, protocol_errors);
        if (value_errors + timing_errors + protocol_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
